// File: gb_bus_arbiter.sv
`timescale 1ns/100ps
`include "gb_bus_defines.svh"

module gb_bus_arbiter (
	input  logic                      gbclk,
	input  logic                      n_crst_in,
	input  gb_bus_pkg::gb_cpu_bus_t   cpu,
	input  gb_bus_pkg::gb_dma_bus_t   dma,
	input  gb_bus_pkg::gb_ppu_bus_t   ppu,
	input  gb_bus_pkg::gb_region_t    cpu_rgn,
	input  gb_bus_pkg::gb_region_t    dma_rgn,
	output gb_bus_pkg::gb_mem_port_t  vram,
	output gb_bus_pkg::gb_mem_port_t  oam,
	output gb_bus_pkg::gb_ext_port_t  ext
);

	logic dma_ext;
	logic wr_q;

	// Offset within the memory window.
	function automatic logic [`GB_ADR_W-1:0] vram_ofs(input logic [`GB_ADR_W-1:0] a);
		return {{(`GB_ADR_W-`GB_VRAM_ADR_W){1'b0}}, a[`GB_VRAM_ADR_W-1:0]};
	endfunction

	function automatic logic [`GB_ADR_W-1:0] oam_ofs(input logic [`GB_OAM_ADR_W-1:0] a);
		return {{(`GB_ADR_W-`GB_OAM_ADR_W){1'b0}}, a};
	endfunction

	assign dma_ext = dma.active && (dma_rgn.rom || dma_rgn.xram || dma_rgn.wram);

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Pixel unit, then DMA, then CPU.
	always_comb begin
		vram     = '0;
		vram.din = cpu.dout; // Only the CPU writes.
		if (ppu.need_vram) begin
			vram.adr = vram_ofs(ppu.adr);
			vram.rd  = ppu.rd;
		end else if (dma.active && dma_rgn.vram) begin
			vram.adr = vram_ofs(dma.rd_adr);
			vram.rd  = dma.rd;
		end else if (cpu_rgn.vram) begin
			vram.adr = vram_ofs(cpu.adr.word);
			vram.rd  = cpu.rd;
			vram.wr  = cpu.wr;
		end
	end

	always_comb begin
		oam = '0;
		if (ppu.need_oam) begin
			oam.adr = oam_ofs(ppu.adr[`GB_OAM_ADR_W-1:0]);
			oam.rd  = ppu.rd;
		end else if (dma.active) begin
			oam.adr = oam_ofs(dma.oam_adr); // DMA owns OAM for the whole transfer.
			oam.wr  = dma.wr;
			oam.din = dma.dout;
		end else if (cpu_rgn.oam) begin
			oam.adr = oam_ofs(cpu.adr.word[`GB_OAM_ADR_W-1:0]);
			oam.rd  = cpu.rd;
			oam.wr  = cpu.wr;
			oam.din = cpu.dout;
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// External bus.
	always_comb begin
		if (dma_ext) begin
			ext.adr = dma.rd_adr;
			ext.rd  = dma.rd;
			ext.wr  = 1'b0;
		end else begin
			ext.adr = cpu.adr.word;
			ext.rd  = cpu.rd;
			ext.wr  = cpu.wr;
		end
		ext.cs_rom  = cpu_rgn.rom || (dma.active && dma_rgn.rom);
		ext.cs_xram = cpu_rgn.xram || (dma.active && dma_rgn.xram);
		ext.cs_wram = cpu_rgn.wram || (dma.active && dma_rgn.wram);
		ext.data_oe = ext.wr || wr_q; // Hold drivers one cycle past the write.
	end

	always_ff @(posedge gbclk) begin
		if (!n_crst_in)
			wr_q <= 1'b0;
		else
			wr_q <= ext.wr;
	end

endmodule

// File: gb_bus_defines.svh
`ifndef GB_BUS_DEFINES_SVH
`define GB_BUS_DEFINES_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Bus widths.
`define GB_ADR_W      16
`define GB_DATA_W     8
`define GB_VRAM_ADR_W 13
`define GB_OAM_ADR_W  8

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// CPU memory map.
`define BOOT_TOP 16'h00FF // Boot ROM overlay end.
`define ROM_TOP  16'h7FFF
`define VRAM_LO  16'h8000
`define VRAM_HI  16'h9FFF
`define XRAM_LO  16'hA000
`define XRAM_HI  16'hBFFF
`define WRAM_LO  16'hC000
`define WRAM_HI  16'hFDFF // Includes the echo area.
`define OAM_LO   16'hFE00
`define OAM_HI   16'hFE9F
`define IO_PAGE  8'hFF

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Register offsets within the I/O page.
`define IO_JOY     8'h00
`define IO_SIO_LO  8'h01
`define IO_SIO_HI  8'h02
`define IO_TIM_LO  8'h04
`define IO_TIM_HI  8'h07
`define IO_IF      8'h0F
`define IO_SND_LO  8'h10
`define IO_SND_HI  8'h3F
`define IO_PPU_LO  8'h40
`define IO_PPU_HI  8'h4B
`define IO_BROM    8'h50
`define IO_HRAM_LO 8'h80
`define IO_HRAM_HI 8'hFE
`define IO_IE      8'hFF

`define RST_TICKS 16    // Edges per reset phase.
`define OPEN_BUS  8'hFF

`endif

// File: gb_bus_pkg.sv
`include "gb_bus_defines.svh"

package gb_bus_pkg;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// One address word, seen whole or as page and register byte.
	typedef union packed {
		logic [`GB_ADR_W-1:0] word;
		struct packed {
			logic [`GB_ADR_W-`GB_DATA_W-1:0] page;
			logic [`GB_DATA_W-1:0]           ofs;
		} io;
	} gb_adr_u;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Requester buses.
	typedef struct packed {
		gb_adr_u               adr;
		logic                  rd;
		logic                  wr;
		logic [`GB_DATA_W-1:0] dout;
	} gb_cpu_bus_t;

	typedef struct packed {
		logic                     active;
		logic [`GB_ADR_W-1:0]     rd_adr;  // Source side.
		logic [`GB_OAM_ADR_W-1:0] oam_adr; // OAM side.
		logic                     rd;
		logic                     wr;
		logic [`GB_DATA_W-1:0]    dout;
	} gb_dma_bus_t;

	typedef struct packed {
		logic                 need_vram;
		logic                 need_oam;
		logic [`GB_ADR_W-1:0] adr;
		logic                 rd;
	} gb_ppu_bus_t;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Target ports.
	typedef struct packed {
		logic [`GB_ADR_W-1:0]  adr;
		logic                  rd;
		logic                  wr;
		logic [`GB_DATA_W-1:0] din;
	} gb_mem_port_t;

	typedef struct packed {
		logic [`GB_ADR_W-1:0] adr;
		logic                 rd;
		logic                 wr;
		logic                 cs_rom;
		logic                 cs_xram;
		logic                 cs_wram;
		logic                 data_oe;
	} gb_ext_port_t;

	typedef struct packed {
		logic brom, rom, vram, xram, wram, oam, io;
	} gb_region_t;

	typedef struct packed {
		logic joy, sio, tim, iflag, snd, ppu, brom, hram, ie;
	} gb_io_sel_t;

	typedef struct packed {
		logic [`GB_DATA_W-1:0] hram, joy, sio, tim, snd, ppu, cpureg, brom;
	} gb_periph_rd_t;

endpackage

// File: gb_bus_properties.sv
`timescale 1ns/100ps

module gb_bus_properties (
	input logic                     gbclk,
	input logic                     n_crst_in,
	input gb_bus_pkg::gb_cpu_bus_t  cpu,
	input gb_bus_pkg::gb_dma_bus_t  dma,
	input gb_bus_pkg::gb_ppu_bus_t  ppu,
	input gb_bus_pkg::gb_region_t   cpu_rgn,
	input gb_bus_pkg::gb_mem_port_t oam,
	input gb_bus_pkg::gb_ext_port_t ext
);

	logic dma_oam_wr;
	logic cpu_oam_wr;

	assign dma_oam_wr = dma.active && dma.wr && !ppu.need_oam;
	assign cpu_oam_wr = cpu.wr && cpu_rgn.oam && !dma.active && !ppu.need_oam;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	oam_one_writer: assert property (@(posedge gbclk) disable iff (!n_crst_in)
		oam.wr |-> (oam.din == (dma_oam_wr ? dma.dout : cpu.dout)))
		else $error("OAM write data does not come from its one writer");

	oam_wr_source: assert property (@(posedge gbclk) disable iff (!n_crst_in)
		oam.wr |-> (dma_oam_wr || cpu_oam_wr))
		else $error("OAM write with no owning writer");

	oe_hold: assert property (@(posedge gbclk) disable iff (!n_crst_in)
		ext.wr |=> ext.data_oe)
		else $error("data_oe low in the cycle after an external write");

endmodule

bind gb_bus_arbiter gb_bus_properties props (
	.gbclk(gbclk), .n_crst_in(n_crst_in), .cpu(cpu), .dma(dma), .ppu(ppu),
	.cpu_rgn(cpu_rgn), .oam(oam), .ext(ext)
);

// File: gb_bus_tb.sv
`timescale 1ns/100ps

module gb_bus_tb;

	typedef struct packed {
		logic [15:0] adr;
		logic [3:0]  rwdd; // CPU rd, CPU wr, DMA active, DMA wr.
		logic [7:0]  dout;
		logic [15:0] dadr;
		logic [1:0]  need; // need_vram, need_oam.
		logic [2:0]  cs;   // rom, xram, wram.
		logic [8:0]  io;
		logic [3:0]  src;  // CPU read source.
		logic [7:0]  own;  // VRAM owner, OAM owner, DMA source, ext by DMA, data_oe.
	} vec_t;

	logic gbclk, n_crst_in, gb_on_req;
	gb_bus_pkg::gb_cpu_bus_t   cpu;
	gb_bus_pkg::gb_dma_bus_t   dma;
	gb_bus_pkg::gb_ppu_bus_t   ppu;
	logic [7:0]                vram_dout, oam_dout, ext_din;
	gb_bus_pkg::gb_periph_rd_t periph;
	gb_bus_pkg::gb_mem_port_t  vram, oam;
	gb_bus_pkg::gb_ext_port_t  ext;
	gb_bus_pkg::gb_io_sel_t    io_sel;
	logic [7:0]                cpu_din, dma_din;
	logic                      hide_bootrom, reset_gb, reset_done;

	vec_t        vecs[$];
	int          errors, tests, failed, cycles;
	logic [15:0] lfsr;
	logic        hide_exp;

	gb_bus_top dut0 (.*);

	initial begin
		gbclk = 1'b0;
		forever #20 gbclk = ~gbclk;
	end

	always @(posedge gbclk) begin
		cycles++;
		if (cycles > 200 + vecs.size()) begin
			$display("Timeout, the run did not finish in %0d cycles.", cycles);
			$display("** FAIL **");
			$finish;
		end
	end

	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
	endfunction

	task automatic rand_byte(output logic [7:0] b);
		for (int i = 0; i < 8; i++) begin
			b = {b[6:0], lfsr[0]};
			lfsr = lfsr_next(lfsr); // One step per bit.
		end
	endtask

	task automatic add_vec(input logic [15:0] adr, input logic [3:0] rwdd, input logic [7:0] dout,
		input logic [15:0] dadr, input logic [1:0] need, input logic [2:0] cs,
		input logic [8:0] io, input logic [3:0] src, input logic [7:0] own);
		vecs.push_back({adr, rwdd, dout, dadr, need, cs, io, src, own});
	endtask

	function automatic logic [7:0] src_byte(input logic [3:0] s);
		case (s)
			4'd1:    return periph.hram;
			4'd2:    return periph.joy;
			4'd3:    return periph.sio;
			4'd4:    return periph.tim;
			4'd5:    return periph.snd;
			4'd6:    return periph.ppu;
			4'd7:    return periph.cpureg;
			4'd8:    return periph.brom;
			4'd9:    return vram_dout;
			4'd10:   return oam_dout;
			4'd11:   return ext_din;
			default: return 8'hFF; // Open bus.
		endcase
	endfunction

	task automatic check_eq(input string what, input logic [15:0] got, input logic [15:0] exp);
		assert (got === exp) else begin
			$display("** Error @%0t: %s is %h, expected %h", $time, what, got, exp);
			errors++;
		end
	endtask

	task automatic apply(input vec_t v);
		cpu.adr.word  = v.adr;
		cpu.rd        = v.rwdd[3];
		cpu.wr        = v.rwdd[2];
		cpu.dout      = v.dout;
		dma.active    = v.rwdd[1];
		dma.rd        = v.rwdd[1];
		dma.wr        = v.rwdd[0];
		dma.rd_adr    = v.dadr;
		dma.oam_adr   = v.dadr[15:8];
		dma.dout      = 8'hC3;
		ppu.need_vram = v.need[1];
		ppu.need_oam  = v.need[0];
		ppu.rd        = |v.need;
		ppu.adr       = 16'h9E77;
		rand_byte(vram_dout);
		rand_byte(oam_dout);
		rand_byte(ext_din);
		rand_byte(periph.hram);
		rand_byte(periph.joy);
		rand_byte(periph.sio);
		rand_byte(periph.tim);
		rand_byte(periph.snd);
		rand_byte(periph.ppu);
		rand_byte(periph.cpureg);
		rand_byte(periph.brom);
	endtask

	task automatic check_vec(input vec_t v);
		logic [15:0] va, oa;
		logic [7:0]  dexp;
		logic        owr, vrd, ord;
		case (v.own[7:6])
			2'd1:    va = 16'h1E77;
			2'd2:    va = {3'b000, v.dadr[12:0]};
			2'd3:    va = {3'b000, v.adr[12:0]};
			default: va = 16'h0000;
		endcase
		case (v.own[5:4])
			2'd1:    oa = 16'h0077;
			2'd2:    oa = {8'h00, v.dadr[15:8]};
			2'd3:    oa = {8'h00, v.adr[7:0]};
			default: oa = 16'h0000;
		endcase
		owr  = (v.own[5:4] == 2'd2) ? v.rwdd[0] : (v.own[5:4] == 2'd3) && v.rwdd[2];
		vrd  = (v.own[7:6] == 2'd1) || (v.own[7:6] == 2'd2 && v.rwdd[1]) ||
			(v.own[7:6] == 2'd3 && v.rwdd[3]);
		ord  = (v.own[5:4] == 2'd1) || (v.own[5:4] == 2'd3 && v.rwdd[3]);
		dexp = (v.own[3:2] == 2'd1) ? vram_dout : (v.own[3:2] == 2'd2) ? ext_din : 8'hFF;
		check_eq("chip selects", 16'({ext.cs_rom, ext.cs_xram, ext.cs_wram}), 16'(v.cs));
		check_eq("io_sel", 16'(io_sel), 16'(v.io));
		check_eq("cpu_din", 16'(cpu_din), 16'(src_byte(v.src)));
		check_eq("vram.adr", vram.adr, va);
		check_eq("vram.rd", 16'(vram.rd), 16'(vrd));
		check_eq("vram.wr", 16'(vram.wr), 16'(v.own[7:6] == 2'd3 && v.rwdd[2]));
		check_eq("oam.adr", oam.adr, oa);
		check_eq("oam.rd", 16'(oam.rd), 16'(ord));
		check_eq("oam.wr", 16'(oam.wr), 16'(owr));
		if (owr)
			check_eq("oam.din", 16'(oam.din), 16'((v.own[5:4] == 2'd2) ? 8'hC3 : v.dout));
		check_eq("dma_din", 16'(dma_din), 16'(dexp));
		check_eq("ext.adr", ext.adr, v.own[1] ? v.dadr : v.adr);
		check_eq("ext.rd", 16'(ext.rd), 16'(v.own[1] ? v.rwdd[1] : v.rwdd[3]));
		check_eq("ext.wr", 16'(ext.wr), 16'(!v.own[1] && v.rwdd[2]));
		check_eq("ext.data_oe", 16'(ext.data_oe), 16'(v.own[0]));
		check_eq("hide_bootrom", 16'(hide_bootrom), 16'(hide_exp));
	endtask

	task automatic wait_done(output int n);
		n = 0;
		while (!reset_done && n < 100) begin
			@(posedge gbclk);
			#1;
			n++;
		end
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	task automatic run_reset();
		int n;
		check_eq("reset_done at release", 16'(reset_done), 16'h0);
		check_eq("reset_gb at release", 16'(reset_gb), 16'h1);
		check_eq("hide_bootrom at release", 16'(hide_bootrom), 16'h0);
		wait_done(n);
		assert (n >= 32 && n <= 64) else begin
			$display("reset_done rose after %0d cycles, not within 32 to 64.", n);
			errors++;
		end
		check_eq("reset_gb after done", 16'(reset_gb), 16'h0);
		@(negedge gbclk);
		gb_on_req = 1'b0; // Power switch off.
		@(posedge gbclk);
		#1;
		check_eq("reset_done after switch", 16'(reset_done), 16'h0);
		check_eq("reset_gb after switch", 16'(reset_gb), 16'h1);
		repeat (4) @(negedge gbclk);
		gb_on_req = 1'b1;
		wait_done(n);
		assert (n <= 64) else begin
			$display("reset_done did not rise again after the power switch.");
			errors++;
		end
		check_eq("reset_gb after power on", 16'(reset_gb), 16'h0);
	endtask

	initial begin
		int e0;
		lfsr = 16'd15590;
		errors = 0;
		tests = 0;
		failed = 0;
		cycles = 0;
		hide_exp = 1'b0;
		n_crst_in = 1'b0;
		gb_on_req = 1'b1;
		// Regions, edges and gap.
		add_vec(16'h0010, 4'b1000, 8'h00, 16'hFEA0, 2'b00, 3'b000, 9'h000, 4'd8, 8'b00_00_00_00);
		add_vec(16'h0100, 4'b1000, 8'h00, 16'hFEA0, 2'b00, 3'b100, 9'h000, 4'd11, 8'b00_00_00_00);
		add_vec(16'h7FFF, 4'b1000, 8'h00, 16'hFEA0, 2'b00, 3'b100, 9'h000, 4'd11, 8'b00_00_00_00);
		add_vec(16'h8000, 4'b1000, 8'h00, 16'hFEA0, 2'b00, 3'b000, 9'h000, 4'd9, 8'b11_00_00_00);
		add_vec(16'hA000, 4'b1000, 8'h00, 16'hFEA0, 2'b00, 3'b010, 9'h000, 4'd11, 8'b00_00_00_00);
		add_vec(16'hBFFF, 4'b1000, 8'h00, 16'hFEA0, 2'b00, 3'b010, 9'h000, 4'd11, 8'b00_00_00_00);
		add_vec(16'hC000, 4'b1000, 8'h00, 16'hFEA0, 2'b00, 3'b001, 9'h000, 4'd11, 8'b00_00_00_00);
		add_vec(16'hFDFF, 4'b1000, 8'h00, 16'hFEA0, 2'b00, 3'b001, 9'h000, 4'd11, 8'b00_00_00_00);
		add_vec(16'hFE00, 4'b1000, 8'h00, 16'hFEA0, 2'b00, 3'b000, 9'h000, 4'd10, 8'b00_11_00_00);
		add_vec(16'hFE9F, 4'b1000, 8'h00, 16'hFEA0, 2'b00, 3'b000, 9'h000, 4'd10, 8'b00_11_00_00);
		add_vec(16'hFEA0, 4'b1000, 8'h00, 16'hFEA0, 2'b00, 3'b000, 9'h000, 4'd0, 8'b00_00_00_00);
		add_vec(16'hFEFF, 4'b1000, 8'h00, 16'hFEA0, 2'b00, 3'b000, 9'h000, 4'd0, 8'b00_00_00_00);
		// I/O page.
		add_vec(16'hFF00, 4'b1000, 8'h00, 16'hFEA0, 2'b00, 3'b000, 9'h100, 4'd2, 8'b00_00_00_00);
		add_vec(16'hFF01, 4'b1000, 8'h00, 16'hFEA0, 2'b00, 3'b000, 9'h080, 4'd3, 8'b00_00_00_00);
		add_vec(16'hFF03, 4'b1000, 8'h00, 16'hFEA0, 2'b00, 3'b000, 9'h000, 4'd0, 8'b00_00_00_00);
		add_vec(16'hFF04, 4'b1000, 8'h00, 16'hFEA0, 2'b00, 3'b000, 9'h040, 4'd4, 8'b00_00_00_00);
		add_vec(16'hFF0F, 4'b1000, 8'h00, 16'hFEA0, 2'b00, 3'b000, 9'h020, 4'd7, 8'b00_00_00_00);
		add_vec(16'hFF10, 4'b1000, 8'h00, 16'hFEA0, 2'b00, 3'b000, 9'h010, 4'd5, 8'b00_00_00_00);
		add_vec(16'hFF40, 4'b1000, 8'h00, 16'hFEA0, 2'b00, 3'b000, 9'h008, 4'd6, 8'b00_00_00_00);
		add_vec(16'hFF4C, 4'b1000, 8'h00, 16'hFEA0, 2'b00, 3'b000, 9'h000, 4'd0, 8'b00_00_00_00);
		add_vec(16'hFF80, 4'b1000, 8'h00, 16'hFEA0, 2'b00, 3'b000, 9'h002, 4'd1, 8'b00_00_00_00);
		add_vec(16'hFFFF, 4'b1000, 8'h00, 16'hFEA0, 2'b00, 3'b000, 9'h001, 4'd7, 8'b00_00_00_00);
		// Boot ROM hide with a zero write first.
		add_vec(16'hFF50, 4'b0100, 8'h00, 16'hFEA0, 2'b00, 3'b000, 9'h004, 4'd0, 8'b00_00_00_01);
		add_vec(16'h0010, 4'b1000, 8'h00, 16'hFEA0, 2'b00, 3'b000, 9'h000, 4'd8, 8'b00_00_00_01);
		add_vec(16'hFF50, 4'b0100, 8'h01, 16'hFEA0, 2'b00, 3'b000, 9'h004, 4'd0, 8'b00_00_00_01);
		add_vec(16'h0010, 4'b1000, 8'h00, 16'hFEA0, 2'b00, 3'b100, 9'h000, 4'd11, 8'b00_00_00_01);
		// Priorities.
		add_vec(16'h8000, 4'b1000, 8'h00, 16'hFEA0, 2'b10, 3'b000, 9'h000, 4'd0, 8'b01_00_00_00);
		add_vec(16'h8000, 4'b1010, 8'h00, 16'h8456, 2'b00, 3'b000, 9'h000, 4'd0, 8'b10_10_01_00);
		add_vec(16'h8000, 4'b1010, 8'h00, 16'h8456, 2'b10, 3'b000, 9'h000, 4'd0, 8'b01_10_00_00);
		add_vec(16'hFE10, 4'b1000, 8'h00, 16'hFEA0, 2'b01, 3'b000, 9'h000, 4'd0, 8'b00_01_00_00);
		add_vec(16'hFE10, 4'b1011, 8'h00, 16'hC100, 2'b00, 3'b001, 9'h000, 4'd0, 8'b00_10_10_10);
		add_vec(16'hFE10, 4'b1010, 8'h00, 16'hC100, 2'b11, 3'b001, 9'h000, 4'd0, 8'b01_01_10_10);
		add_vec(16'hA010, 4'b1010, 8'h00, 16'h0200, 2'b00, 3'b110, 9'h000, 4'd0, 8'b00_10_10_10);
		// Write hold on the external bus.
		add_vec(16'hC000, 4'b0100, 8'h5A, 16'hFEA0, 2'b00, 3'b001, 9'h000, 4'd0, 8'b00_00_00_01);
		add_vec(16'hC001, 4'b1000, 8'h00, 16'hFEA0, 2'b00, 3'b001, 9'h000, 4'd11, 8'b00_00_00_01);
		add_vec(16'hC002, 4'b1000, 8'h00, 16'hFEA0, 2'b00, 3'b001, 9'h000, 4'd11, 8'b00_00_00_00);
		apply(vec_t'(0));
		repeat (3) @(posedge gbclk);
		@(negedge gbclk);
		n_crst_in = 1'b1;
		e0 = errors;
		run_reset();
		tests++;
		if (errors != e0)
			failed++;
		$display("test %0d reset sequence: %s", tests, (errors == e0) ? "ok" : "failed");
		foreach (vecs[i]) begin
			e0 = errors;
			@(negedge gbclk);
			apply(vecs[i]);
			#10; // Settled ahead of the rising edge.
			check_vec(vecs[i]);
			if (vecs[i].rwdd[2] && vecs[i].adr == 16'hFF50 && vecs[i].dout != 8'h00)
				hide_exp = 1'b1; // Nonzero BROM write hides the boot ROM.
			tests++;
			if (errors != e0)
				failed++;
			$display("test %0d adr %h: %s", tests, vecs[i].adr, (errors == e0) ? "ok" : "failed");
		end
		$display("%0d tests, %0d failed, %0d errors", tests, failed, errors);
		if (errors == 0)
			$display("** PASS **");
		else
			$display("** FAIL **");
		$finish;
	end

endmodule

// File: gb_bus_top.f
+incdir+.
gb_bus_pkg.sv
gb_memmap.sv
gb_iomap.sv
gb_bus_arbiter.sv
gb_read_mux.sv
gb_reset_seq.sv
gb_bus_top.sv
gb_bus_properties.sv
gb_bus_tb.sv

// File: gb_bus_top.sv
`timescale 1ns/100ps
`include "gb_bus_defines.svh"

module gb_bus_top (
	input  logic                      gbclk,
	input  logic                      n_crst_in,
	input  logic                      gb_on_req,
	input  gb_bus_pkg::gb_cpu_bus_t   cpu,
	input  gb_bus_pkg::gb_dma_bus_t   dma,
	input  gb_bus_pkg::gb_ppu_bus_t   ppu,
	input  logic [`GB_DATA_W-1:0]     vram_dout,
	input  logic [`GB_DATA_W-1:0]     oam_dout,
	input  logic [`GB_DATA_W-1:0]     ext_din,
	input  gb_bus_pkg::gb_periph_rd_t periph,
	output gb_bus_pkg::gb_mem_port_t  vram,
	output gb_bus_pkg::gb_mem_port_t  oam,
	output gb_bus_pkg::gb_ext_port_t  ext,
	output gb_bus_pkg::gb_io_sel_t    io_sel,
	output logic [`GB_DATA_W-1:0]     cpu_din,
	output logic [`GB_DATA_W-1:0]     dma_din,
	output logic                      hide_bootrom,
	output logic                      reset_gb,
	output logic                      reset_done
);

	gb_bus_pkg::gb_region_t cpu_rgn;
	gb_bus_pkg::gb_region_t dma_rgn;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Address decode.
	gb_memmap #(.boot_overlay(1'b1)) cpu_map (
		.adr          (cpu.adr),
		.hide_bootrom (hide_bootrom),
		.rgn          (cpu_rgn)
	);

	gb_memmap #(.boot_overlay(1'b0)) dma_map (
		.adr          (dma.rd_adr),
		.hide_bootrom (1'b1), // DMA never sees the boot ROM.
		.rgn          (dma_rgn)
	);

	gb_iomap io_map (
		.gbclk        (gbclk),
		.n_crst_in    (n_crst_in),
		.reset_gb     (reset_gb),
		.cpu          (cpu),
		.io_page      (cpu_rgn.io),
		.io_sel       (io_sel),
		.hide_bootrom (hide_bootrom)
	);

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	gb_bus_arbiter arb (
		.gbclk, .n_crst_in, .cpu, .dma, .ppu, .cpu_rgn, .dma_rgn, .vram, .oam, .ext
	);

	gb_read_mux rd_mux (
		.cpu, .dma, .ppu, .cpu_rgn, .dma_rgn, .io_sel,
		.vram_dout, .oam_dout, .ext_din, .periph, .cpu_din, .dma_din
	);

	gb_reset_seq rst_seq (
		.gbclk      (gbclk),
		.n_crst_in  (n_crst_in),
		.gb_on_req  (gb_on_req),
		.reset_done (reset_done),
		.reset_gb   (reset_gb)
	);

endmodule

// File: gb_iomap.sv
`timescale 1ns/100ps
`include "gb_bus_defines.svh"

module gb_iomap (
	input  logic                    gbclk,
	input  logic                    n_crst_in,
	input  logic                    reset_gb,
	input  gb_bus_pkg::gb_cpu_bus_t cpu,
	input  logic                    io_page,
	output gb_bus_pkg::gb_io_sel_t  io_sel,
	output logic                    hide_bootrom
);

	logic [`GB_DATA_W-1:0] ofs;
	logic                  hide_set;

	assign ofs = cpu.adr.io.ofs;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Register decode.
	always_comb begin
		io_sel = '0;
		if (io_page) begin
			io_sel.joy   = ofs == `IO_JOY;
			io_sel.sio   = ofs >= `IO_SIO_LO && ofs <= `IO_SIO_HI;
			io_sel.tim   = ofs >= `IO_TIM_LO && ofs <= `IO_TIM_HI;
			io_sel.iflag = ofs == `IO_IF;
			io_sel.snd   = ofs >= `IO_SND_LO && ofs <= `IO_SND_HI;
			io_sel.ppu   = ofs >= `IO_PPU_LO && ofs <= `IO_PPU_HI;
			io_sel.brom  = ofs == `IO_BROM;
			io_sel.hram  = ofs >= `IO_HRAM_LO && ofs <= `IO_HRAM_HI;
			io_sel.ie    = ofs == `IO_IE;
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Boot ROM hide. Any nonzero write locks the ROM out.
	assign hide_set = cpu.wr && io_sel.brom && (cpu.dout != '0);

	always_ff @(posedge gbclk) begin
		if (!n_crst_in) begin
			hide_bootrom <= 1'b0;
		end else if (reset_gb) begin
			hide_bootrom <= 1'b0; // Console reset shows it again.
		end else if (hide_set) begin
			hide_bootrom <= 1'b1;
		end
	end

endmodule

// File: gb_memmap.sv
`timescale 1ns/100ps
`include "gb_bus_defines.svh"

module gb_memmap #(
	parameter bit boot_overlay = 1'b1
) (
	input  gb_bus_pkg::gb_adr_u    adr,
	input  logic                   hide_bootrom,
	output gb_bus_pkg::gb_region_t rgn
);

	logic [`GB_ADR_W-1:0] a;

	assign a = adr.word;

	// At most one select; the gap above OAM selects nothing.
	always_comb begin
		rgn = '0;
		if (adr.io.page == `IO_PAGE) begin
			rgn.io = 1'b1;
		end else if (a >= `OAM_LO && a <= `OAM_HI) begin
			rgn.oam = 1'b1;
		end else if (a >= `WRAM_LO && a <= `WRAM_HI) begin
			rgn.wram = 1'b1;
		end else if (a >= `XRAM_LO && a <= `XRAM_HI) begin
			rgn.xram = 1'b1;
		end else if (a >= `VRAM_LO && a <= `VRAM_HI) begin
			rgn.vram = 1'b1;
		end else if (a <= `ROM_TOP) begin
			if (boot_overlay && !hide_bootrom && a <= `BOOT_TOP)
				rgn.brom = 1'b1; // Overlay on cartridge ROM.
			else
				rgn.rom = 1'b1;
		end
	end

endmodule

// File: gb_read_mux.sv
`timescale 1ns/100ps
`include "gb_bus_defines.svh"

module gb_read_mux (
	input  gb_bus_pkg::gb_cpu_bus_t   cpu,
	input  gb_bus_pkg::gb_dma_bus_t   dma,
	input  gb_bus_pkg::gb_ppu_bus_t   ppu,
	input  gb_bus_pkg::gb_region_t    cpu_rgn,
	input  gb_bus_pkg::gb_region_t    dma_rgn,
	input  gb_bus_pkg::gb_io_sel_t    io_sel,
	input  logic [`GB_DATA_W-1:0]     vram_dout,
	input  logic [`GB_DATA_W-1:0]     oam_dout,
	input  logic [`GB_DATA_W-1:0]     ext_din,
	input  gb_bus_pkg::gb_periph_rd_t periph,
	output logic [`GB_DATA_W-1:0]     cpu_din,
	output logic [`GB_DATA_W-1:0]     dma_din
);

	logic cpu_ext;
	logic dma_ext;

	assign cpu_ext = cpu_rgn.rom || cpu_rgn.xram || cpu_rgn.wram;
	assign dma_ext = dma_rgn.rom || dma_rgn.xram || dma_rgn.wram;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// CPU read data, first match wins.
	always_comb begin
		cpu_din = `OPEN_BUS;
		if (!cpu.rd)
			cpu_din = `OPEN_BUS; // Idle bus floats high.
		else if (io_sel.hram)
			cpu_din = periph.hram;
		else if (io_sel.joy)
			cpu_din = periph.joy;
		else if (io_sel.sio)
			cpu_din = periph.sio;
		else if (io_sel.tim)
			cpu_din = periph.tim;
		else if (io_sel.snd)
			cpu_din = periph.snd;
		else if (io_sel.ppu)
			cpu_din = periph.ppu;
		else if (io_sel.iflag || io_sel.ie)
			cpu_din = periph.cpureg; // Both live in the CPU.
		else if (cpu_rgn.brom)
			cpu_din = periph.brom;
		else if (cpu_rgn.vram && !ppu.need_vram && !(dma.active && dma_rgn.vram))
			cpu_din = vram_dout;
		else if (cpu_rgn.oam && !dma.active && !ppu.need_oam)
			cpu_din = oam_dout;
		else if (cpu_ext && !(dma.active && dma_ext))
			cpu_din = ext_din;
	end

	// DMA source data.
	always_comb begin
		if (dma_rgn.vram && !ppu.need_vram)
			dma_din = vram_dout;
		else if (dma_ext)
			dma_din = ext_din;
		else
			dma_din = `OPEN_BUS;
	end

endmodule

// File: gb_reset_seq.sv
`timescale 1ns/100ps
`include "gb_bus_defines.svh"

module gb_reset_seq (
	input  logic gbclk,
	input  logic n_crst_in,
	input  logic gb_on_req,
	output logic reset_done,
	output logic reset_gb
);

	localparam int cnt_w = $clog2(`RST_TICKS);
	localparam logic [cnt_w-1:0] last_tick = cnt_w'(`RST_TICKS - 1);

	// One-hot phase.
	localparam logic [2:0] s_assert  = 3'b001;
	localparam logic [2:0] s_release = 3'b010;
	localparam logic [2:0] s_done    = 3'b100;

	logic [cnt_w-1:0] por_cnt;
	logic             por_done;
	logic [2:0]       state;
	logic [cnt_w-1:0] ph_cnt;
	logic             gb_on_q;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_ff @(posedge gbclk) begin
		if (!n_crst_in) begin
			por_cnt  <= '0;
			por_done <= 1'b0;
			state    <= s_assert;
			ph_cnt   <= '0;
			gb_on_q  <= 1'b0;
		end else begin
			gb_on_q <= gb_on_req;

			// Power-on delay.
			if (!por_done) begin
				por_cnt <= por_cnt + 1'b1;
				if (por_cnt == last_tick)
					por_done <= 1'b1;
			end

			if (gb_on_req != gb_on_q) begin
				state  <= s_assert; // Power switch moved.
				ph_cnt <= '0;
			end else if (por_done) begin
				if (state == s_assert) begin
					if (ph_cnt == last_tick) begin
						state  <= s_release;
						ph_cnt <= '0;
					end else begin
						ph_cnt <= ph_cnt + 1'b1;
					end
				end else if (state == s_release) begin
					if (ph_cnt == last_tick)
						state <= s_done;
					else
						ph_cnt <= ph_cnt + 1'b1;
				end
			end
		end
	end

	assign reset_done = (state == s_done);
	assign reset_gb   = !reset_done || !gb_on_req;

endmodule

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f gb_bus_top.f --top-module gb_bus_tb -o gb_bus_sim
out=$(./obj_dir/gb_bus_sim)
echo "$out"
echo "$out" | grep -qx '\*\* PASS \*\*'
